//--- hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

  // widths that carry a meaning
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  alu_ctrl_t;

  // alu operation codes
  localparam alu_ctrl_t ALU_AND = 3'b000;
  localparam alu_ctrl_t ALU_OR  = 3'b001;
  localparam alu_ctrl_t ALU_ADD = 3'b010;
  localparam alu_ctrl_t ALU_SUB = 3'b110;
  localparam alu_ctrl_t ALU_SLT = 3'b111;

  // primary opcodes, instr[31:26]
  localparam logic [5:0] OP_RTYPE = 6'b000000;
  localparam logic [5:0] OP_LW    = 6'b100011;
  localparam logic [5:0] OP_SW    = 6'b101011;
  localparam logic [5:0] OP_BEQ   = 6'b000100;
  localparam logic [5:0] OP_ADDI  = 6'b001000;
  localparam logic [5:0] OP_J     = 6'b000010;
  localparam logic [5:0] OP_JAL   = 6'b000011;

  // r-type function codes, instr[5:0]
  localparam logic [5:0] FN_ADD  = 6'b100000;
  localparam logic [5:0] FN_SUB  = 6'b100010;
  localparam logic [5:0] FN_AND  = 6'b100100;
  localparam logic [5:0] FN_OR   = 6'b100101;
  localparam logic [5:0] FN_SLT  = 6'b101010;
  localparam logic [5:0] FN_MULT = 6'b011000;
  localparam logic [5:0] FN_MFHI = 6'b010000;
  localparam logic [5:0] FN_MFLO = 6'b010010;
  localparam logic [5:0] FN_JR   = 6'b001000;

  // link register for jal
  localparam reg_addr_t REG_RA = 5'd31;

  localparam word_t PC_RESET = 32'h0000_0000;

  // datapath control word, 13 bits
  typedef struct packed {
    logic      memtoreg;
    logic      alusrc;
    logic      regdst;
    logic      regwrite;
    logic      jump;
    logic      jumpreg;
    logic      link;
    logic      mult;
    logic      mfhi;
    logic      mflo;
    alu_ctrl_t alucontrol;
  } ctrl_t;

endpackage

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import mips_pkg::*; (
  input  wire logic clk,
  input  wire logic we,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  input  reg_addr_t wa,
  input  word_t     wd,
  output word_t     rd1,
  output word_t     rd2
);

  word_t regs [0:31];

  // writes to r0 are dropped
  always_ff @(posedge clk) begin
    if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // r0 reads as zero whatever the array holds
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

  a_r0_zero_b : assert property (
    @(posedge clk) (ra2 == '0) |-> (rd2 == '0)
  );

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import mips_pkg::*; (
  input  word_t     in_a,
  input  word_t     in_b,
  input  alu_ctrl_t op,
  output word_t     result,
  output logic      zero
);

  word_t sum;
  word_t diff;
  logic  less;

  assign sum  = in_a + in_b;
  assign diff = in_a - in_b;

  // signed compare for slt
  assign less = $signed(in_a) < $signed(in_b);

  always_comb begin
    case (op)
      ALU_AND: result = in_a & in_b;
      ALU_OR:  result = in_a | in_b;
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_SLT: result = {31'b0, less};
      default: result = '0;
    endcase
  end

  // beq uses this with ALU_SUB
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hdl/hilo_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_multiplier import mips_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic en,
  input  word_t     in_a,
  input  word_t     in_b,
  output word_t     hi,
  output word_t     lo
);

  logic signed [63:0] product;

  // full signed 64-bit product of rs and rt
  assign product = $signed(in_a) * $signed(in_b);

  always_ff @(posedge clk) begin
    if (rst) begin
      hi <= '0;
      lo <= '0;
    end else if (en) begin
      hi <= product[63:32];
      lo <= product[31:0];
    end
  end

endmodule

`default_nettype wire

//--- hdl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import mips_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  ctrl_t     ctrl,
  input  wire logic pcsrc,
  input  word_t     instr,
  input  word_t     readdata,
  output logic      zero,
  output word_t     pc,
  output word_t     aluout,
  output word_t     writedata
);

  // instruction fields
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;

  // next pc
  word_t pc_next;
  word_t pc_plus4;
  word_t pc_branch;
  word_t pc_jump;

  // operands and results
  word_t     sign_imm;
  word_t     src_a;
  word_t     src_b;
  word_t     hi;
  word_t     lo;
  word_t     hilo_out;
  word_t     alu_or_hilo;
  word_t     result;
  word_t     rf_wdata;
  reg_addr_t write_reg;
  reg_addr_t rf_waddr;

  assign rs = instr[25:21];
  assign rt = instr[20:16];
  assign rd = instr[15:11];

  assign sign_imm  = {{16{instr[15]}}, instr[15:0]};
  assign pc_plus4  = pc + 32'd4;
  assign pc_branch = pc_plus4 + {sign_imm[29:0], 2'b00};
  assign pc_jump   = {4'b0, instr[25:0], 2'b00};

  // jr over j over taken beq
  always_comb begin
    if (ctrl.jumpreg) begin
      pc_next = src_a;
    end else if (ctrl.jump) begin
      pc_next = pc_jump;
    end else if (pcsrc) begin
      pc_next = pc_branch;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= PC_RESET;
    end else begin
      pc <= pc_next;
    end
  end

  // destination register, r31 on jal
  assign write_reg = ctrl.regdst ? rd : rt;
  assign rf_waddr  = ctrl.link ? REG_RA : write_reg;

  regfile u_regfile (
    .clk (clk),
    .we  (ctrl.regwrite),
    .ra1 (rs),
    .ra2 (rt),
    .wa  (rf_waddr),
    .wd  (rf_wdata),
    .rd1 (src_a),
    .rd2 (writedata)
  );

  assign src_b = ctrl.alusrc ? sign_imm : writedata;

  alu u_alu (
    .in_a   (src_a),
    .in_b   (src_b),
    .op     (ctrl.alucontrol),
    .result (aluout),
    .zero   (zero)
  );

  hilo_multiplier u_hilo (
    .clk  (clk),
    .rst  (rst),
    .en   (ctrl.mult),
    .in_a (src_a),
    .in_b (writedata),
    .hi   (hi),
    .lo   (lo)
  );

  // result chain: hi/lo, then load data, then return address
  assign hilo_out    = ctrl.mfhi ? hi : lo;
  assign alu_or_hilo = (ctrl.mfhi || ctrl.mflo) ? hilo_out : aluout;
  assign result      = ctrl.memtoreg ? readdata : alu_or_hilo;
  assign rf_wdata    = ctrl.link ? pc_plus4 : result;

  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
  );

  // decoder must never ask for both halves at once
  a_hilo_onehot : assert property (
    @(posedge clk) disable iff (rst) !(ctrl.mfhi && ctrl.mflo)
  );

endmodule

`default_nettype wire

//--- hdl/controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller import mips_pkg::*; (
  input  wire logic [5:0] op,
  input  wire logic [5:0] funct,
  input  wire logic       zero,
  output ctrl_t           ctrl,
  output logic            pcsrc,
  output logic            memwrite
);

  logic      branch;
  alu_ctrl_t alu_sel;

  // alu decoder
  always_comb begin
    case (op)
      OP_RTYPE: begin
        case (funct)
          FN_SUB:  alu_sel = ALU_SUB;
          FN_AND:  alu_sel = ALU_AND;
          FN_OR:   alu_sel = ALU_OR;
          FN_SLT:  alu_sel = ALU_SLT;
          default: alu_sel = ALU_ADD;
        endcase
      end
      OP_BEQ:  alu_sel = ALU_SUB;
      default: alu_sel = ALU_ADD;
    endcase
  end

  // main decoder, everything inactive unless the opcode says otherwise
  always_comb begin
    ctrl     = '0;
    memwrite = 1'b0;
    branch   = 1'b0;
    case (op)
      OP_RTYPE: begin
        ctrl.regdst = 1'b1;
        case (funct)
          FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: begin
            ctrl.regwrite = 1'b1;
          end
          FN_MULT: ctrl.mult = 1'b1;
          FN_MFHI: begin
            ctrl.mfhi     = 1'b1;
            ctrl.regwrite = 1'b1;
          end
          FN_MFLO: begin
            ctrl.mflo     = 1'b1;
            ctrl.regwrite = 1'b1;
          end
          FN_JR:   ctrl.jumpreg = 1'b1;
          // unknown funct, including the all-zero nop, writes nothing
          default: ctrl.regdst = 1'b0;
        endcase
      end
      OP_LW: begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.memtoreg = 1'b1;
      end
      OP_SW: begin
        ctrl.alusrc = 1'b1;
        memwrite    = 1'b1;
      end
      OP_BEQ:  branch = 1'b1;
      OP_ADDI: begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
      end
      OP_J:    ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regwrite = 1'b1;
      end
      default: branch = 1'b0;
    endcase
    ctrl.alucontrol = alu_sel;
  end

  assign pcsrc = branch & zero;

  // no instruction writes both memory and the register file
  always_comb begin
    a_no_dual_write : assert (!(memwrite && ctrl.regwrite));
  end

endmodule

`default_nettype wire

//--- hdl/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,
  input  word_t     instr,
  input  word_t     readdata,
  output word_t     pc,
  output word_t     aluout,
  output word_t     writedata,
  output logic      memwrite
);

  ctrl_t ctrl;
  logic  pcsrc;
  logic  zero;

  controller u_controller (
    .op       (instr[31:26]),
    .funct    (instr[5:0]),
    .zero     (zero),
    .ctrl     (ctrl),
    .pcsrc    (pcsrc),
    .memwrite (memwrite)
  );

  // aluout doubles as the data memory address
  datapath u_datapath (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .pcsrc     (pcsrc),
    .instr     (instr),
    .readdata  (readdata),
    .zero      (zero),
    .pc        (pc),
    .aluout    (aluout),
    .writedata (writedata)
  );

endmodule

`default_nettype wire

//--- verif/mips_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb import mips_pkg::*; ();

  localparam int          NUM_TESTS = 33;
  localparam int          MEM_WORDS = 64;
  localparam logic [31:0] LCG_SEED  = 32'd95793;

  // one program step and what the core must show while it executes
  typedef struct packed {
    word_t instr;
    word_t pc;
    logic  store;
    word_t addr;
    word_t data;
  } entry_t;

  logic  clk;
  logic  rst;
  word_t instr;
  word_t readdata;
  word_t pc;
  word_t aluout;
  word_t writedata;
  logic  memwrite;

  word_t  dmem [0:MEM_WORDS-1];
  entry_t prog [0:NUM_TESTS-1];
  string  names [0:NUM_TESTS-1];
  int     num_entries;
  word_t  cur_pc;
  int     passed;
  int     failed;

  mips_core UUT (
    .clk       (clk),
    .rst       (rst),
    .instr     (instr),
    .readdata  (readdata),
    .pc        (pc),
    .aluout    (aluout),
    .writedata (writedata),
    .memwrite  (memwrite)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // data memory, read combinationally from the alu address
  assign readdata = dmem[aluout[7:2]];

  always @(posedge clk) begin
    if (memwrite) begin
      dmem[aluout[7:2]] = writedata;
    end
  end

  function automatic word_t lcg_next(input word_t state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic word_t sext16(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  function automatic word_t enc_r(input reg_addr_t rs, input reg_addr_t rt,
                                  input reg_addr_t rd, input logic [5:0] fn);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs,
                                  input reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t enc_j(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic fill_memory();
    word_t state;
    state = LCG_SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      state = lcg_next(state);
      dmem[i] = state;
    end
  endtask

  // the expected pc of each entry is the pc the previous entry leads to
  task automatic add_entry(input string name, input word_t ins, input logic store,
                           input word_t addr, input word_t data);
    if (num_entries < NUM_TESTS) begin
      prog[num_entries] = '{ins, cur_pc, store, addr, data};
      names[num_entries] = name;
    end
    num_entries++;
    cur_pc = cur_pc + 32'd4;
  endtask

  task automatic build_program();
    logic [15:0] imm_a;
    logic [15:0] imm_b;
    word_t       va;
    word_t       vb;
    word_t       pre0;
    word_t       pre1;
    logic [63:0] prod;
    word_t       link;
    imm_a = 16'd1234;
    // -567
    imm_b = 16'hfdc9;
    va = sext16(imm_a);
    vb = sext16(imm_b);
    pre0 = dmem[0];
    pre1 = dmem[1];
    prod = {{32{pre0[31]}}, pre0} * {{32{pre1[31]}}, pre1};
    num_entries = 0;
    cur_pc = PC_RESET;

    // state right after reset, hi and lo still cleared
    add_entry("reset_nop", 32'h0, 1'b0, '0, '0);
    add_entry("mfhi_early", enc_r(5'd0, 5'd0, 5'd8, FN_MFHI), 1'b0, '0, '0);
    add_entry("mflo_early", enc_r(5'd0, 5'd0, 5'd9, FN_MFLO), 1'b0, '0, '0);
    add_entry("sw_hi_zero", enc_i(OP_SW, 5'd0, 5'd8, 16'h0040), 1'b1, 32'h40, '0);
    add_entry("sw_lo_zero", enc_i(OP_SW, 5'd0, 5'd9, 16'h0044), 1'b1, 32'h44, '0);

    // arithmetic and logic
    add_entry("addi_r1", enc_i(OP_ADDI, 5'd0, 5'd1, imm_a), 1'b0, '0, '0);
    add_entry("addi_r2", enc_i(OP_ADDI, 5'd0, 5'd2, imm_b), 1'b0, '0, '0);
    add_entry("add", enc_r(5'd1, 5'd2, 5'd3, FN_ADD), 1'b0, '0, '0);
    add_entry("sub", enc_r(5'd1, 5'd2, 5'd4, FN_SUB), 1'b0, '0, '0);
    add_entry("and", enc_r(5'd1, 5'd2, 5'd5, FN_AND), 1'b0, '0, '0);
    add_entry("or", enc_r(5'd1, 5'd2, 5'd6, FN_OR), 1'b0, '0, '0);
    add_entry("slt", enc_r(5'd2, 5'd1, 5'd7, FN_SLT), 1'b0, '0, '0);
    add_entry("sw_add", enc_i(OP_SW, 5'd0, 5'd3, 16'h0048), 1'b1, 32'h48, va + vb);
    add_entry("sw_sub", enc_i(OP_SW, 5'd0, 5'd4, 16'h004c), 1'b1, 32'h4c, va - vb);
    add_entry("sw_and", enc_i(OP_SW, 5'd0, 5'd5, 16'h0050), 1'b1, 32'h50, va & vb);
    add_entry("sw_or", enc_i(OP_SW, 5'd0, 5'd6, 16'h0054), 1'b1, 32'h54, va | vb);
    add_entry("sw_slt", enc_i(OP_SW, 5'd0, 5'd7, 16'h0058), 1'b1, 32'h58,
              ($signed(vb) < $signed(va)) ? 32'd1 : 32'd0);

    // loads from preloaded words, stored back elsewhere
    add_entry("lw_r10", enc_i(OP_LW, 5'd0, 5'd10, 16'h0000), 1'b0, '0, '0);
    add_entry("lw_r11", enc_i(OP_LW, 5'd0, 5'd11, 16'h0004), 1'b0, '0, '0);
    add_entry("sw_r10", enc_i(OP_SW, 5'd0, 5'd10, 16'h005c), 1'b1, 32'h5c, pre0);
    add_entry("sw_r11", enc_i(OP_SW, 5'd0, 5'd11, 16'h0060), 1'b1, 32'h60, pre1);

    // signed multiply of the loaded words
    add_entry("mult", enc_r(5'd10, 5'd11, 5'd0, FN_MULT), 1'b0, '0, '0);
    add_entry("mfhi", enc_r(5'd0, 5'd0, 5'd12, FN_MFHI), 1'b0, '0, '0);
    add_entry("mflo", enc_r(5'd0, 5'd0, 5'd13, FN_MFLO), 1'b0, '0, '0);
    add_entry("sw_hi", enc_i(OP_SW, 5'd0, 5'd12, 16'h0064), 1'b1, 32'h64, prod[63:32]);
    add_entry("sw_lo", enc_i(OP_SW, 5'd0, 5'd13, 16'h0068), 1'b1, 32'h68, prod[31:0]);

    // branches, target is pc+4 plus the offset in words
    add_entry("beq_taken", enc_i(OP_BEQ, 5'd1, 5'd1, 16'd2), 1'b0, '0, '0);
    cur_pc = cur_pc + (sext16(16'd2) << 2);
    add_entry("beq_not_taken", enc_i(OP_BEQ, 5'd1, 5'd2, 16'd5), 1'b0, '0, '0);

    // jump target is the 26-bit field shifted left by 2
    add_entry("j", enc_j(OP_J, 26'h40), 1'b0, '0, '0);
    cur_pc = {6'b0, 26'h40} << 2;
    add_entry("jal", enc_j(OP_JAL, 26'h80), 1'b0, '0, '0);
    link = cur_pc;
    cur_pc = {6'b0, 26'h80} << 2;
    add_entry("sw_link", enc_i(OP_SW, 5'd0, 5'd31, 16'h006c), 1'b1, 32'h6c, link);
    add_entry("jr", enc_r(5'd31, 5'd0, 5'd0, FN_JR), 1'b0, '0, '0);
    cur_pc = link;
    add_entry("after_jr", 32'h0, 1'b0, '0, '0);
  endtask

  task automatic check_entry(input int idx);
    entry_t e;
    logic   ok;
    e = prog[idx];
    ok = 1'b1;
    assert (pc === e.pc) else begin
      $display("FAILED %s pc expected %h actual %h", names[idx], e.pc, pc);
      ok = 1'b0;
    end
    assert (memwrite === e.store) else begin
      $display("FAILED %s memwrite expected %b actual %b", names[idx], e.store, memwrite);
      ok = 1'b0;
    end
    // address and data only mean something on a store
    if (e.store) begin
      assert (aluout === e.addr) else begin
        $display("FAILED %s aluout expected %h actual %h", names[idx], e.addr, aluout);
        ok = 1'b0;
      end
      assert (writedata === e.data) else begin
        $display("FAILED %s writedata expected %h actual %h", names[idx], e.data, writedata);
        ok = 1'b0;
      end
    end
    if (ok) begin
      passed++;
      $display("PASS   %s", names[idx]);
    end else begin
      failed++;
    end
  endtask

  initial begin
    rst = 1'b1;
    instr = '0;
    passed = 0;
    failed = 0;
    fill_memory();
    build_program();
    assert (num_entries == NUM_TESTS) else begin
      $display("program table holds %0d entries instead of %0d", num_entries, NUM_TESTS);
      failed++;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    // new instruction just after the edge, outputs sampled at the falling edge
    for (int i = 0; i < NUM_TESTS; i++) begin
      instr = prog[i].instr;
      @(negedge clk);
      check_entry(i);
      @(posedge clk);
      #1;
    end
    $display("summary: %0d run, %0d passed, %0d failed", NUM_TESTS, passed, failed);
    if (failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog, reset plus one cycle per entry plus some slack
  initial begin
    #((8 + NUM_TESTS + 10) * 10);
    $display("timeout: the program did not finish within %0d cycles", 8 + NUM_TESTS + 10);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hdl/mips_pkg.sv
hdl/regfile.sv
hdl/alu.sv
hdl/hilo_multiplier.sv
hdl/datapath.sv
hdl/controller.sv
hdl/mips_core.sv
verif/mips_core_tb.sv

//--- Makefile
TOP := mips_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		--Mdir obj_dir -f files.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
